// ==== hw/imuldiv_pkg.sv ====
// ---------------------------------------------------------------------
// shared widths, queue sizes and types of the multiply/divide unit
// every block of the unit imports what it needs from here
// ---------------------------------------------------------------------
package imuldiv_pkg;

  // operand and response widths
  localparam int OPERAND_W = 32;
  localparam int RESULT_W  = 64;

  // iteration counter of both execute units, counts 0..31
  localparam int STEP_CNT_W = 5;

  // request slots, also the upstream credits after reset
  localparam int REQ_DEPTH = 2;
  // response slots inside the result block
  localparam int RESP_DEPTH = 2;
  // response credits held after reset, matches downstream buffer
  localparam int RESP_CREDITS = 2;

  // function codes carried by each request
  typedef enum logic [2:0] {
    fn_mul  = 3'd0,
    fn_div  = 3'd1,
    fn_divu = 3'd2,
    fn_rem  = 3'd3,
    fn_remu = 3'd4
  } imuldiv_fn_t;

  // queued request, 3 + 32 + 32 = 67 bits
  typedef struct packed {
    imuldiv_fn_t          fn;
    logic [OPERAND_W-1:0] a;
    logic [OPERAND_W-1:0] b;
  } imuldiv_req_t;

  // FSM states shared by the multiplier and the divider
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_load = 2'd1,
    st_calc = 2'd2,
    st_fix  = 2'd3
  } exec_state_t;

endpackage

// ==== hw/credit_queue.sv ====
// ---------------------------------------------------------------------
// small circular FIFO with a type parameter for the payload
// holds requests at the top level and responses in the result block
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module credit_queue #(
  parameter type payload_t = logic [63:0],
  parameter int  DEPTH     = 2
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       push,
  input  payload_t                   push_data,
  input  logic                       pop,
  output payload_t                   head,
  output logic                       not_empty,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  // one pointer bit minimum, even for a single slot
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // pointer advance with wrap at DEPTH, works for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // storage, written at the tail
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers and occupancy
  // no full check, upstream never pushes without a credit
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // entry pushed in cycle N shows at the head in N+1
  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

endmodule

// ==== hw/imuldiv_decode.sv ====
// ---------------------------------------------------------------------
// takes requests off the request queue and starts one execute unit
// dispatches only when both units are idle and a result slot is free
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_decode (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                not_empty,
  input  imuldiv_pkg::imuldiv_req_t           head,
  output logic                                pop,
  input  logic                                slot_free,
  input  logic                                mul_busy,
  input  logic                                div_busy,
  output logic                                mul_start,
  output logic                                div_start,
  output logic [imuldiv_pkg::OPERAND_W-1:0]   op_a,
  output logic [imuldiv_pkg::OPERAND_W-1:0]   op_b,
  output logic                                op_signed,
  output logic                                want_rem
);

  import imuldiv_pkg::*;

  logic dispatch;
  logic is_mul;

  // ------------------------------------------------------------------
  // function code decode
  // ------------------------------------------------------------------
  assign is_mul = (head.fn == fn_mul);

  // decision in the cycle the head shows up
  // a start pulse in flight blocks a second decision on the same head,
  // busy covers the unit from the cycle after start until done
  assign dispatch = not_empty && slot_free && !mul_busy && !div_busy &&
                    !mul_start && !div_start;

  // ------------------------------------------------------------------
  // registered dispatch, start and pop one cycle after the decision
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      pop       <= 1'b0;
      mul_start <= 1'b0;
      div_start <= 1'b0;
    end else begin
      pop       <= dispatch;
      mul_start <= dispatch && is_mul;
      div_start <= dispatch && !is_mul;
    end
  end

  // operands and divider controls, held until the next dispatch
  always_ff @(posedge clk) begin
    if (dispatch) begin
      op_a      <= head.a;
      op_b      <= head.b;
      // signed for div and rem only
      op_signed <= (head.fn == fn_div) || (head.fn == fn_rem);
      // remainder for rem and remu
      want_rem  <= (head.fn == fn_rem) || (head.fn == fn_remu);
    end
  end

endmodule

// ==== hw/imuldiv_mul_iterative.sv ====
// ---------------------------------------------------------------------
// signed multiplier, one shift-and-add step per cycle over 32 cycles
// start to done is 34 cycles: load, 32 steps, sign fix
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_mul_iterative (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] a,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] b,
  output logic                              busy,
  output logic                              done,
  output logic [imuldiv_pkg::RESULT_W-1:0]  product
);

  import imuldiv_pkg::*;

  exec_state_t           state;
  logic [STEP_CNT_W-1:0] step;

  // datapath
  logic [RESULT_W-1:0]  mcand;
  logic [OPERAND_W-1:0] mplier;
  logic [RESULT_W-1:0]  acc;
  logic                 neg;

  // operand magnitudes, two's complement of negatives
  logic [OPERAND_W-1:0] a_mag;
  logic [OPERAND_W-1:0] b_mag;

  assign a_mag = a[OPERAND_W-1] ? (~a + 1'b1) : a;
  assign b_mag = b[OPERAND_W-1] ? (~b + 1'b1) : b;

  // ------------------------------------------------------------------
  // control FSM
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      step  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_load;
          end
        end
        st_load: begin
          step  <= '0;
          state <= st_calc;
        end
        st_calc: begin
          step <= step + 1'b1;
          // last of 32 steps
          if (step == '1) begin
            state <= st_fix;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // shift-and-add datapath
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        // capture magnitudes and product sign on start
        if (start) begin
          mcand  <= {{(RESULT_W-OPERAND_W){1'b0}}, a_mag};
          mplier <= b_mag;
          neg    <= a[OPERAND_W-1] ^ b[OPERAND_W-1];
        end
      end
      st_load: begin
        acc <= '0;
      end
      st_calc: begin
        // add shifted multiplicand when the low multiplier bit is set
        if (mplier[0]) begin
          acc <= acc + mcand;
        end
        mcand  <= mcand << 1;
        mplier <= mplier >> 1;
      end
      default: begin
        acc <= acc;
      end
    endcase
  end

  assign busy = (state != st_idle);
  // one-cycle pulse in the fix state
  assign done = (state == st_fix);
  // negate when the operand signs differ
  assign product = neg ? (~acc + 1'b1) : acc;

endmodule

// ==== hw/imuldiv_div_iterative.sv ====
// ---------------------------------------------------------------------
// restoring divider, one quotient bit per cycle, signed or unsigned
// start to done is 34 cycles, quotient or remainder selected at the end
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_div_iterative (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              start,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] a,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] b,
  input  logic                              is_signed,
  input  logic                              want_rem,
  output logic                              busy,
  output logic                              done,
  output logic [imuldiv_pkg::OPERAND_W-1:0] value
);

  import imuldiv_pkg::*;

  exec_state_t           state;
  logic [STEP_CNT_W-1:0] step;

  // quo starts as the dividend and fills with quotient bits
  logic [OPERAND_W-1:0] quo;
  logic [OPERAND_W-1:0] rem;
  logic [OPERAND_W-1:0] dvs;
  logic                 q_neg;
  logic                 r_neg;
  logic                 sel_rem;

  logic                 a_neg;
  logic                 b_neg;
  logic [OPERAND_W-1:0] a_mag;
  logic [OPERAND_W-1:0] b_mag;

  // partial remainder shifted left by one, and trial difference
  // two extra bits so the borrow lands in the top bit
  logic [OPERAND_W:0]   shifted;
  logic [OPERAND_W+1:0] diff;

  logic [OPERAND_W-1:0] q_fix;
  logic [OPERAND_W-1:0] r_fix;

  assign a_neg = is_signed && a[OPERAND_W-1];
  assign b_neg = is_signed && b[OPERAND_W-1];
  assign a_mag = a_neg ? (~a + 1'b1) : a;
  assign b_mag = b_neg ? (~b + 1'b1) : b;

  assign shifted = {rem, quo[OPERAND_W-1]};
  assign diff    = {1'b0, shifted} - {2'b00, dvs};

  // ------------------------------------------------------------------
  // control FSM, same sequence as the multiplier
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      step  <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_load;
          end
        end
        st_load: begin
          step  <= '0;
          state <= st_calc;
        end
        st_calc: begin
          step <= step + 1'b1;
          if (step == '1) begin
            state <= st_fix;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ------------------------------------------------------------------
  // restoring division datapath
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (start) begin
          quo     <= a_mag;
          dvs     <= b_mag;
          // zero divisor keeps the all-ones quotient unsigned
          q_neg   <= (a_neg ^ b_neg) && (b != '0);
          // remainder follows the dividend sign
          r_neg   <= a_neg;
          sel_rem <= want_rem;
        end
      end
      st_load: begin
        rem <= '0;
      end
      st_calc: begin
        // no borrow: subtract and set the quotient bit
        if (!diff[OPERAND_W+1]) begin
          rem <= diff[OPERAND_W-1:0];
          quo <= {quo[OPERAND_W-2:0], 1'b1};
        end else begin
          rem <= shifted[OPERAND_W-1:0];
          quo <= {quo[OPERAND_W-2:0], 1'b0};
        end
      end
      default: begin
        rem <= rem;
      end
    endcase
  end

  // sign fix in the final cycle
  assign q_fix = q_neg ? (~quo + 1'b1) : quo;
  assign r_fix = r_neg ? (~rem + 1'b1) : rem;

  assign busy  = (state != st_idle);
  assign done  = (state == st_fix);
  assign value = sel_rem ? r_fix : q_fix;

endmodule

// ==== hw/imuldiv_result.sv ====
// ---------------------------------------------------------------------
// queues finished results and sends them downstream under credits
// also reports to decode whether a response slot can be reserved
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_result (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              mul_done,
  input  logic [imuldiv_pkg::RESULT_W-1:0]  mul_product,
  input  logic                              div_done,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] div_value,
  input  logic                              dispatched,
  output logic                              slot_free,
  input  logic                              resp_credit,
  output logic                              resp_val,
  output logic [imuldiv_pkg::RESULT_W-1:0]  resp_result
);

  import imuldiv_pkg::*;

  localparam int CREDIT_W = $clog2(RESP_CREDITS + 1);
  localparam int QCOUNT_W = $clog2(RESP_DEPTH + 1);

  logic                push;
  logic [RESULT_W-1:0] push_data;
  logic                q_not_empty;
  logic [QCOUNT_W-1:0] q_count;
  logic [CREDIT_W-1:0] credits;
  // an operation sits in execute with a slot reserved
  logic                in_exec;

  // division results zero-extended into the low half
  assign push      = mul_done || div_done;
  assign push_data = mul_done ? mul_product
                              : {{(RESULT_W-OPERAND_W){1'b0}}, div_value};

  credit_queue #(
    .payload_t (logic [RESULT_W-1:0]),
    .DEPTH     (RESP_DEPTH)
  ) resp_q (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .push_data (push_data),
    .pop       (resp_val),
    .head      (resp_result),
    .not_empty (q_not_empty),
    .count     (q_count)
  );

  // one response per cycle while a credit is held
  assign resp_val = q_not_empty && (credits != '0);

  // ------------------------------------------------------------------
  // response credits and slot reservation
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(RESP_CREDITS);
      in_exec <= 1'b0;
    end else begin
      case ({resp_val, resp_credit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
      // reservation moves into the queue on done
      if (dispatched) begin
        in_exec <= 1'b1;
      end else if (push) begin
        in_exec <= 1'b0;
      end
    end
  end

  // queued results plus the one executing stay below the queue depth
  assign slot_free = ((QCOUNT_W+1)'(q_count) + (QCOUNT_W+1)'(in_exec)) <
                     (QCOUNT_W+1)'(RESP_DEPTH);

endmodule

// ==== hw/imuldiv_top.sv ====
// ---------------------------------------------------------------------
// iterative multiply/divide unit with credit flow control on both sides
// request queue, decode, multiplier, divider and result block
// ---------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_top (
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              req_val,
  input  imuldiv_pkg::imuldiv_fn_t          req_fn,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] req_a,
  input  logic [imuldiv_pkg::OPERAND_W-1:0] req_b,
  output logic                              req_credit,
  input  logic                              resp_credit,
  output logic                              resp_val,
  output logic [imuldiv_pkg::RESULT_W-1:0]  resp_result
);

  import imuldiv_pkg::*;

  imuldiv_req_t         req_in;
  imuldiv_req_t         q_head;
  logic                 q_not_empty;
  logic                 req_pop;

  logic                 slot_free;
  logic                 mul_busy;
  logic                 div_busy;
  logic                 mul_start;
  logic                 div_start;
  logic [OPERAND_W-1:0] op_a;
  logic [OPERAND_W-1:0] op_b;
  logic                 op_signed;
  logic                 want_rem;

  logic                 mul_done;
  logic [RESULT_W-1:0]  mul_product;
  logic                 div_done;
  logic [OPERAND_W-1:0] div_value;

  // ------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------
  assign req_in = '{fn: req_fn, a: req_a, b: req_b};
  // credit back upstream as each request leaves the queue
  assign req_credit = req_pop;

  credit_queue #(
    .payload_t (imuldiv_req_t),
    .DEPTH     (REQ_DEPTH)
  ) req_q (
    .clk       (clk),
    .reset     (reset),
    .push      (req_val),
    .push_data (req_in),
    .pop       (req_pop),
    .head      (q_head),
    .not_empty (q_not_empty),
    .count     ()
  );

  imuldiv_decode decode (
    .clk       (clk),
    .reset     (reset),
    .not_empty (q_not_empty),
    .head      (q_head),
    .pop       (req_pop),
    .slot_free (slot_free),
    .mul_busy  (mul_busy),
    .div_busy  (div_busy),
    .mul_start (mul_start),
    .div_start (div_start),
    .op_a      (op_a),
    .op_b      (op_b),
    .op_signed (op_signed),
    .want_rem  (want_rem)
  );

  // ------------------------------------------------------------------
  // execute units, only one runs at a time
  // ------------------------------------------------------------------
  imuldiv_mul_iterative mul (
    .clk     (clk),
    .reset   (reset),
    .start   (mul_start),
    .a       (op_a),
    .b       (op_b),
    .busy    (mul_busy),
    .done    (mul_done),
    .product (mul_product)
  );

  imuldiv_div_iterative div (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .a         (op_a),
    .b         (op_b),
    .is_signed (op_signed),
    .want_rem  (want_rem),
    .busy      (div_busy),
    .done      (div_done),
    .value     (div_value)
  );

  // response side, reservation taken on either start pulse
  imuldiv_result result (
    .clk         (clk),
    .reset       (reset),
    .mul_done    (mul_done),
    .mul_product (mul_product),
    .div_done    (div_done),
    .div_value   (div_value),
    .dispatched  (mul_start || div_start),
    .slot_free   (slot_free),
    .resp_credit (resp_credit),
    .resp_val    (resp_val),
    .resp_result (resp_result)
  );

endmodule

// ==== testbench/imuldiv_tb.sv ====
// ----------------------------------------------------------------------
// testbench for the multiply/divide unit, table and LFSR random tests
// credits on both sides are tracked, responses checked in send order
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module imuldiv_tb;

  import imuldiv_pkg::*;

  // table split, first entries are multiplies
  localparam int N_MUL = 10;
  localparam int N_TAB = 29;
  localparam int N_CREDIT_OPS = REQ_DEPTH;
  localparam int N_BP = 6;
  localparam int N_RAND = 40;
  localparam int N_OPS = N_CREDIT_OPS + N_TAB + N_BP + N_RAND;
  localparam int CYCLE_LIMIT = N_OPS * 40 + 200;
  // observation window while response credits are withheld
  localparam int BP_WINDOW = 80;

  typedef struct packed {
    imuldiv_fn_t fn;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] exp_val;
  } vec_t;

  // ----------------------------------------------------------------------
  // stimulus table with hand computed results
  // ----------------------------------------------------------------------
  vec_t vec_tab [N_TAB] = '{
    '{fn_mul,  32'd7,        32'hFFFFFFFD, 64'hFFFFFFFF_FFFFFFEB},
    '{fn_mul,  32'hFFFFFF00, 32'h00001000, 64'hFFFFFFFF_FFF00000},
    '{fn_mul,  32'hFFFFFFFB, 32'hFFFFFFF7, 64'h00000000_0000002D},
    '{fn_mul,  32'd0,        32'h12345678, 64'h00000000_00000000},
    '{fn_mul,  32'd1,        32'h89ABCDEF, 64'hFFFFFFFF_89ABCDEF},
    '{fn_mul,  32'hFFFFFFFF, 32'h12345678, 64'hFFFFFFFF_EDCBA988},
    '{fn_mul,  32'h80000000, 32'h80000000, 64'h40000000_00000000},
    '{fn_mul,  32'h80000000, 32'hFFFFFFFF, 64'h00000000_80000000},
    '{fn_mul,  32'h7FFFFFFF, 32'h7FFFFFFF, 64'h3FFFFFFF_00000001},
    '{fn_mul,  32'h00010000, 32'h00010000, 64'h00000001_00000000},
    // signed quotient, truncated toward zero
    '{fn_div,  32'd100,      32'd7,        64'h00000000_0000000E},
    '{fn_div,  32'hFFFFFF9C, 32'd7,        64'h00000000_FFFFFFF2},
    '{fn_div,  32'd100,      32'hFFFFFFF9, 64'h00000000_FFFFFFF2},
    '{fn_div,  32'hFFFFFF9C, 32'hFFFFFFF9, 64'h00000000_0000000E},
    '{fn_div,  32'h12345678, 32'd0,        64'h00000000_FFFFFFFF},
    '{fn_div,  32'hFFFFFF9C, 32'd0,        64'h00000000_FFFFFFFF},
    '{fn_div,  32'h80000000, 32'hFFFFFFFF, 64'h00000000_80000000},
    '{fn_divu, 32'hFFFFFFFF, 32'd16,       64'h00000000_0FFFFFFF},
    '{fn_divu, 32'd100,      32'd7,        64'h00000000_0000000E},
    '{fn_divu, 32'h80000000, 32'hFFFFFFFF, 64'h00000000_00000000},
    '{fn_divu, 32'd5,        32'd0,        64'h00000000_FFFFFFFF},
    // remainder keeps the dividend sign
    '{fn_rem,  32'hFFFFFF9C, 32'd7,        64'h00000000_FFFFFFFE},
    '{fn_rem,  32'd100,      32'hFFFFFFF9, 64'h00000000_00000002},
    '{fn_rem,  32'hFFFFFF9C, 32'hFFFFFFF9, 64'h00000000_FFFFFFFE},
    '{fn_rem,  32'hFFFFFF9C, 32'd0,        64'h00000000_FFFFFF9C},
    '{fn_rem,  32'h80000000, 32'hFFFFFFFF, 64'h00000000_00000000},
    '{fn_remu, 32'hFFFFFFFF, 32'd16,       64'h00000000_0000000F},
    '{fn_remu, 32'hFFFFFF9C, 32'd7,        64'h00000000_00000002},
    '{fn_remu, 32'd12345,    32'd0,        64'h00000000_00003039}
  };

  logic        clk = 1'b0;
  logic        reset;
  logic        req_val;
  imuldiv_fn_t req_fn;
  logic [31:0] req_a;
  logic [31:0] req_b;
  logic        req_credit;
  logic        resp_credit;
  logic        resp_val;
  logic [63:0] resp_result;

  // scoreboard and bookkeeping
  logic [63:0] exp_q [$];
  imuldiv_fn_t fn_q [$];
  int          req_credits = REQ_DEPTH;
  int          owed = 0;
  bit          hold = 1'b0;
  int          held_resp = 0;
  int          sent_cnt = 0;
  int          resp_cnt = 0;
  int          credit_pulses = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          t_checks;
  int          t_errs;
  int          cycle_cnt = 0;
  logic [31:0] lfsr = 32'hee8e81ff;
  logic [31:0] ra;
  logic [31:0] rb;
  logic [31:0] rsel;
  imuldiv_fn_t rfn;

  always #2 clk = ~clk;

  imuldiv_top UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_credit  (req_credit),
    .resp_credit (resp_credit),
    .resp_val    (resp_val),
    .resp_result (resp_result)
  );

  // run limit from the number of operations
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d responses still outstanding",
               cycle_cnt, exp_q.size());
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // random source and reference model
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] val);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    val = v;
  endtask

  // signed mul is the full 64-bit product, division results zero-extended
  function automatic logic [63:0] model_result(input imuldiv_fn_t fn,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
    longint      sa;
    longint      sb;
    longint      ua;
    longint      ub;
    logic [31:0] r;
    sa = longint'(signed'(a));
    sb = longint'(signed'(b));
    ua = longint'({32'h0, a});
    ub = longint'({32'h0, b});
    case (fn)
      fn_mul:  return 64'(sa * sb);
      // divide by zero gives all ones, remainder is the dividend
      fn_div:  r = (b == 32'h0) ? 32'hFFFFFFFF : 32'(sa / sb);
      fn_divu: r = (b == 32'h0) ? 32'hFFFFFFFF : 32'(ua / ub);
      fn_rem:  r = (b == 32'h0) ? a : 32'(sa % sb);
      fn_remu: r = (b == 32'h0) ? a : 32'(ua % ub);
      default: r = 32'h0;
    endcase
    return {32'h0, r};
  endfunction

  // ----------------------------------------------------------------------
  // one clock cycle, sample at the falling edge, then drive
  // ----------------------------------------------------------------------
  task automatic tick();
    logic [63:0] exp_val;
    imuldiv_fn_t efn;
    @(negedge clk);
    if (req_credit === 1'b1) begin
      credit_pulses++;
      req_credits++;
      if (credit_pulses > sent_cnt || req_credits > REQ_DEPTH) begin
        $display("req_credit pulsed with no request outstanding at %0t", $time);
        err_cnt++;
      end
    end
    if (resp_val === 1'b1) begin
      resp_cnt++;
      owed++;
      if (hold) begin
        held_resp++;
        if (held_resp > RESP_CREDITS) begin
          $display("response sent without a credit at %0t", $time);
          err_cnt++;
        end
      end
      if (exp_q.size() == 0) begin
        $display("response at %0t with no request outstanding", $time);
        err_cnt++;
      end else begin
        exp_val = exp_q.pop_front();
        efn = fn_q.pop_front();
        check_cnt++;
        if (resp_result !== exp_val) begin
          $display("Fail at %0t: response %0d got %h expected %h",
                   $time, resp_cnt, resp_result, exp_val);
          err_cnt++;
        end
        if (efn != fn_mul && resp_result[63:32] !== 32'h0) begin
          $display("Fail at %0t: division result upper half %h not zero",
                   $time, resp_result[63:32]);
          err_cnt++;
        end
      end
    end
    req_val = 1'b0;
    // downstream hands a credit back per consumed response
    if (!hold && owed > 0) begin
      resp_credit = 1'b1;
      owed--;
    end else begin
      resp_credit = 1'b0;
    end
  endtask

  // waits for a request credit, then sends for one cycle
  task automatic send_op(input imuldiv_fn_t fn, input logic [31:0] a,
                         input logic [31:0] b, input logic [63:0] exp_val);
    while (req_credits == 0) begin
      tick();
    end
    req_val = 1'b1;
    req_fn = fn;
    req_a = a;
    req_b = b;
    req_credits--;
    sent_cnt++;
    exp_q.push_back(exp_val);
    fn_q.push_back(fn);
    tick();
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || owed != 0) begin
      tick();
    end
  endtask

  task automatic start_test();
    t_checks = check_cnt;
    t_errs = err_cnt;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt != t_errs) begin
      tests_failed++;
    end
    $display("test %s: %0d checks, %0d errors", name, check_cnt - t_checks,
             err_cnt - t_errs);
  endtask

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial begin
    reset = 1'b1;
    req_val = 1'b0;
    req_fn = fn_mul;
    req_a = 32'h0;
    req_b = 32'h0;
    resp_credit = 1'b0;

    // outputs stay low during reset and the cycle after
    start_test();
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      if (i == 4) begin
        reset = 1'b0;
      end
      check_cnt++;
      if (resp_val !== 1'b0 || req_credit !== 1'b0) begin
        $display("Fail at %0t: resp_val or req_credit not low around reset", $time);
        err_cnt++;
      end
    end
    finish_test("reset_state");

    // full request credit spent back to back
    start_test();
    send_op(fn_mul, 32'd3, 32'd4, 64'd12);
    send_op(fn_divu, 32'd9, 32'd3, 64'd3);
    wait_drain();
    check_cnt++;
    if (credit_pulses != sent_cnt) begin
      $display("Fail at %0t: %0d req_credit pulses for %0d requests", $time,
               credit_pulses, sent_cnt);
      err_cnt++;
    end
    finish_test("req_credits");

    start_test();
    for (int i = 0; i < N_MUL; i++) begin
      send_op(vec_tab[i].fn, vec_tab[i].a, vec_tab[i].b, vec_tab[i].exp_val);
    end
    wait_drain();
    finish_test("mul_table");

    start_test();
    for (int i = N_MUL; i < N_TAB; i++) begin
      send_op(vec_tab[i].fn, vec_tab[i].a, vec_tab[i].b, vec_tab[i].exp_val);
    end
    wait_drain();
    finish_test("div_table");

    // response credits withheld, unit must stall without loss
    start_test();
    hold = 1'b1;
    held_resp = 0;
    for (int i = 0; i < N_BP; i++) begin
      rfn = imuldiv_fn_t'(3'(i % 5));
      ra = 32'hFFFF0000 | 32'(i * 37 + 11);
      rb = 32'(i + 3);
      send_op(rfn, ra, rb, model_result(rfn, ra, rb));
    end
    repeat (BP_WINDOW) tick();
    check_cnt++;
    if (held_resp != RESP_CREDITS) begin
      $display("Fail at %0t: %0d responses while credits withheld, expected %0d",
               $time, held_resp, RESP_CREDITS);
      err_cnt++;
    end
    hold = 1'b0;
    wait_drain();
    finish_test("backpressure");

    // random codes, divisor sometimes zero or small
    start_test();
    for (int i = 0; i < N_RAND; i++) begin
      rand_bits(3, rsel);
      rfn = imuldiv_fn_t'(3'(rsel % 5));
      rand_bits(32, ra);
      rand_bits(2, rsel);
      if (rsel == 32'd0) begin
        rb = 32'h0;
      end else if (rsel == 32'd1) begin
        rand_bits(4, rb);
      end else begin
        rand_bits(32, rb);
      end
      send_op(rfn, ra, rb, model_result(rfn, ra, rb));
    end
    wait_drain();
    finish_test("random_mix");

    check_cnt++;
    if (credit_pulses != sent_cnt || resp_cnt != sent_cnt) begin
      $display("Fail at %0t: %0d sent, %0d req_credit pulses, %0d responses",
               $time, sent_cnt, credit_pulses, resp_cnt);
      err_cnt++;
    end
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hw/imuldiv_pkg.sv
hw/credit_queue.sv
hw/imuldiv_decode.sv
hw/imuldiv_mul_iterative.sv
hw/imuldiv_div_iterative.sv
hw/imuldiv_result.sv
hw/imuldiv_top.sv
testbench/imuldiv_tb.sv

// ==== Makefile ====
# Verilator lint and simulation of the iterative multiply/divide unit
TOP = imuldiv_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

# the run passes only when the log holds the pass line
sim:
	verilator --binary --timing -f compile.f --top-module $(TOP) --Mdir obj_dir -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
